//--- sim/router_tb.sv
`timescale 1ns/1ns
`include "router_config.svh"

module router_tb;

    import flit_pkg::*;
    import route_pkg::*;

    localparam coord_t MY_X = 2'd1;
    localparam coord_t MY_Y = 2'd2;
    localparam int N_RANDOM = 300;
    localparam int TOTAL_FLITS = `NUM_PORT * `NUM_VC * `VC_DEPTH + N_RANDOM + 2 * (`VC_DEPTH + 2);
    localparam int CYCLE_LIMIT = 20 * TOTAL_FLITS;
    localparam int NO_LIMIT = 1 << 30;

    logic      clk;
    logic      rst;
    port_vec_t in_valid;
    flit_t     in_flit    [`NUM_PORT];
    vc_vec_t   credit_out [`NUM_PORT];
    port_vec_t out_valid;
    flit_t     out_flit   [`NUM_PORT];
    vc_vec_t   credit_in  [`LOCAL_PORT];
    vc_vec_t   give       [`LOCAL_PORT];

    // Expected flits, indexed by payload tag
    flit_t    exp_flit [TOTAL_FLITS];
    port_id_t exp_port [TOTAL_FLITS];
    int       exp_src  [TOTAL_FLITS];
    int       exp_seq  [TOTAL_FLITS];
    bit       seen     [TOTAL_FLITS];
    int       inj_cnt  [`NUM_PORT][`NUM_PORT][`NUM_VC];
    int       del_cnt  [`NUM_PORT][`NUM_PORT][`NUM_VC];

    int    up_credit  [`NUM_PORT][`NUM_VC];
    int    ds_owed    [`LOCAL_PORT][`NUM_VC];
    int    ret_budget [`LOCAL_PORT];
    flit_t last_flit  [`NUM_PORT];
    int    port_recv  [`NUM_PORT];
    int    sent_total, recv_total, err_cnt, check_cnt, test_cnt, test_fail, cycle_cnt;

    router #(.MY_X(MY_X), .MY_Y(MY_Y)) DUT (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_flit(in_flit),
        .credit_out(credit_out), .out_valid(out_valid), .out_flit(out_flit),
        .credit_in(credit_in)
    );

    always #50 clk = ~clk;

    //////////////////////
    // Reference model
    //////////////////////

    function automatic port_id_t expected_port(coord_t x, coord_t y);
        if (x > MY_X) return port_id_t'(0);
        if (x < MY_X) return port_id_t'(2);
        if (y > MY_Y) return port_id_t'(1);
        if (y < MY_Y) return port_id_t'(3);
        return port_id_t'(`LOCAL_PORT);
    endfunction

    task automatic compare_flit(input string name, input flit_t got, input flit_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_port(input string name, input port_id_t got, input port_id_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_credit(input string name, input credit_t got, input credit_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_arrival(input int o, input flit_t f);
        int     tag;
        vc_id_t v;
        tag = int'(f[`PAYLOAD_POS]);
        v = f[`VC_POS];
        last_flit[o] = f;
        port_recv[o]++;
        recv_total++;
        if (o < `LOCAL_PORT) begin
            if (ds_owed[o][v] >= `VC_DEPTH) begin
                $display("ERROR at %0t: output %0d vc %0d sent with no credit", $time, o, v);
                err_cnt++;
            end
            ds_owed[o][v]++;
        end
        if (tag >= sent_total || seen[tag]) begin
            $display("ERROR at %0t: unexpected or repeated flit %h on output %0d", $time, f, o);
            err_cnt++;
            return;
        end
        seen[tag] = 1'b1;
        compare_port("arrival port", port_id_t'(o), exp_port[tag]);
        compare_flit("out_flit", f, exp_flit[tag]);
        if (exp_seq[tag] != del_cnt[exp_port[tag]][exp_src[tag]][v]) begin
            $display("ERROR at %0t: flit %0d from input %0d left out of order",
                     $time, tag, exp_src[tag]);
            err_cnt++;
        end
        del_cnt[exp_port[tag]][exp_src[tag]][v]++;
    endtask

    // Outputs and returned credits, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `NUM_PORT; i++) begin
                for (int v = 0; v < `NUM_VC; v++) begin
                    if (credit_out[i][v] && up_credit[i][v] >= `VC_DEPTH) begin
                        $display("ERROR at %0t: credit_out on input %0d vc %0d with no flit held",
                                 $time, i, v);
                        err_cnt++;
                    end else if (credit_out[i][v]) begin
                        up_credit[i][v]++;
                    end
                end
            end
            for (int o = 0; o < `NUM_PORT; o++) begin
                if (out_valid[o]) check_arrival(o, out_flit[o]);
            end
        end
    end

    // Downstream neighbours hand back credits unless held
    initial begin
        for (int o = 0; o < `LOCAL_PORT; o++) credit_in[o] = '0;
        forever begin
            @(posedge clk);
            for (int o = 0; o < `LOCAL_PORT; o++) begin
                for (int v = 0; v < `NUM_VC; v++) begin
                    give[o][v] = (ds_owed[o][v] > 0 && ret_budget[o] > 0);
                    if (give[o][v]) begin
                        ds_owed[o][v]--;
                        ret_budget[o]--;
                    end
                end
            end
            #5;
            for (int o = 0; o < `LOCAL_PORT; o++) credit_in[o] = give[o];
        end
    end

    //////////////////////
    // Stimulus
    //////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #5;
        in_valid = '0;
    endtask

    task automatic load(input int i, input coord_t x, input coord_t y, input vc_id_t v,
                        input stamp_t st);
        flit_t    f;
        port_id_t o;
        if (up_credit[i][v] == 0) begin
            $display("ERROR at %0t: input %0d vc %0d has no credit left", $time, i, v);
            err_cnt++;
            return;
        end
        o = expected_port(x, y);
        f = {x, y, v, st, payload_t'(sent_total)};
        exp_flit[sent_total] = f;
        exp_port[sent_total] = o;
        exp_src[sent_total] = i;
        exp_seq[sent_total] = inj_cnt[o][i][v];
        inj_cnt[o][i][v]++;
        up_credit[i][v]--;
        sent_total++;
        in_valid[i] = 1'b1;
        in_flit[i] = f;
    endtask

    task automatic end_test(input string name, input int err_start);
        int busy;
        busy = 1;
        while (busy != 0) begin
            next_cycle();
            busy = sent_total - recv_total;
            for (int o = 0; o < `LOCAL_PORT; o++) busy += ds_owed[o][0] + ds_owed[o][1];
        end
        repeat (2) next_cycle();
        for (int i = 0; i < `NUM_PORT; i++) begin
            for (int v = 0; v < `NUM_VC; v++) begin
                compare_credit($sformatf("credits of input %0d vc %0d", i, v),
                               credit_t'(up_credit[i][v]), credit_t'(`VC_DEPTH));
            end
        end
        test_cnt++;
        if (err_cnt != err_start) test_fail++;
        $display("test %s: %0d errors", name, err_cnt - err_start);
    endtask

    initial begin
        int     err_start;
        int     count;
        int     base;
        int     tag_old;
        vc_id_t v;
        void'($urandom(11));
        clk = 1'b0;
        rst = 1'b1;
        in_valid = '0;
        for (int i = 0; i < `NUM_PORT; i++) begin
            in_flit[i] = '0;
            up_credit[i] = '{`VC_DEPTH, `VC_DEPTH};
        end
        for (int o = 0; o < `LOCAL_PORT; o++) ret_budget[o] = NO_LIMIT;

        // Idle outputs during reset and just after, then a full burst
        err_start = err_cnt;
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            // Registers hold their reset value only after the first edge
            if (k > 0) begin
                check_cnt++;
                if (out_valid !== '0 || credit_out[0] !== '0 || credit_out[4] !== '0 ||
                    credit_out[1] !== '0 || credit_out[2] !== '0 || credit_out[3] !== '0) begin
                    $display("ERROR at %0t: out_valid or credit_out active around reset", $time);
                    err_cnt++;
                end
            end
            if (k == 7) begin
                @(posedge clk);
                #5 rst = 1'b0;
            end
        end
        for (int k = 0; k < `NUM_VC * `VC_DEPTH; k++) begin
            next_cycle();
            for (int i = 0; i < `NUM_PORT; i++) begin
                load(i, coord_t'($urandom), coord_t'($urandom), vc_id_t'(k % `NUM_VC),
                     stamp_t'($urandom));
            end
        end
        end_test("reset", err_start);

        err_start = err_cnt;
        count = 0;
        while (count < N_RANDOM) begin
            next_cycle();
            for (int i = 0; i < `NUM_PORT; i++) begin
                v = vc_id_t'($urandom_range(1, 0));
                if (count < N_RANDOM && $urandom_range(1, 0) == 1 && up_credit[i][v] > 0) begin
                    load(i, coord_t'($urandom), coord_t'($urandom), v, stamp_t'($urandom));
                    count++;
                end
            end
        end
        end_test("routing", err_start);

        // East output holds its credits
        err_start = err_cnt;
        ret_budget[0] = 0;
        base = port_recv[0];
        for (int k = 0; k < `VC_DEPTH; k++) begin
            next_cycle();
            load(2, 2'd2, 2'd1, 1'b0, stamp_t'($urandom));
        end
        next_cycle();
        load(3, 2'd3, 2'd0, 1'b0, stamp_t'($urandom));
        next_cycle();
        load(3, 2'd2, 2'd3, 1'b0, stamp_t'($urandom));
        repeat (20) next_cycle();
        compare_credit("held credits of output 0", credit_t'(ds_owed[0][0]), credit_t'(`VC_DEPTH));
        check_cnt++;
        if (port_recv[0] - base != `VC_DEPTH) begin
            $display("ERROR at %0t: output 0 passed %0d flits with %0d credits",
                     $time, port_recv[0] - base, `VC_DEPTH);
            err_cnt++;
        end
        ret_budget[0] = NO_LIMIT;
        end_test("back-pressure", err_start);

        err_start = err_cnt;
        ret_budget[0] = 0;
        for (int k = 0; k < `VC_DEPTH; k++) begin
            next_cycle();
            load(4, 2'd3, 2'd2, 1'b0, stamp_t'(10 + k));
        end
        while (ds_owed[0][0] != `VC_DEPTH) next_cycle();
        next_cycle();
        load(1, 2'd2, 2'd0, 1'b0, 8'd200);
        load(3, 2'd3, 2'd3, 1'b0, 8'd50);
        tag_old = sent_total - 1;
        repeat (4) next_cycle();
        base = port_recv[0];
        ret_budget[0] = 1;
        while (port_recv[0] == base) next_cycle();
        compare_flit("first flit after one credit", last_flit[0], exp_flit[tag_old]);
        ret_budget[0] = NO_LIMIT;
        end_test("oldest-first", err_start);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, test_fail, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("sim failed");
        $finish;
    end

endmodule

//--- src/crossbar.sv
`timescale 1ns/1ns
`include "router_config.svh"

module crossbar (
    input  logic                 clk,
    input  logic                 rst,
    input  flit_pkg::flit_t      sel_flit [`NUM_PORT],
    input  route_pkg::port_vec_t xbar_valid,
    input  route_pkg::port_id_t  xbar_src [`NUM_PORT],
    output route_pkg::port_vec_t out_valid,
    output flit_pkg::flit_t      out_flit [`NUM_PORT]
);

    ////////////////////
    // Output registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= '0;
        end else begin
            out_valid <= xbar_valid;
        end
    end

    // Flit is only loaded when its output is granted
    always_ff @(posedge clk) begin
        for (int o = 0; o < `NUM_PORT; o++) begin
            if (xbar_valid[o]) begin
                out_flit[o] <= sel_flit[xbar_src[o]];
            end
        end
    end

endmodule

//--- src/flit_pkg.sv
`include "router_config.svh"

package flit_pkg;

    ////////////////////
    // Flit field types
    ////////////////////

    // One mesh coordinate, X or Y
    typedef logic [`COORD_WIDTH-1:0] coord_t;

    // Virtual channel number carried in the flit
    typedef logic [0:0] vc_id_t;

    // Age stamp, smaller value is older
    typedef logic [`TIME_WIDTH-1:0] stamp_t;

    typedef logic [`PAYLOAD_WIDTH-1:0] payload_t;

    ////////////////////
    // Whole flit
    ////////////////////

    // Layout is {dst_x, dst_y, vc, time, payload}
    typedef logic [`FLIT_WIDTH-1:0] flit_t;

endpackage

//--- src/input_port.sv
`timescale 1ns/1ns
`include "router_config.svh"

module input_port #(
    parameter flit_pkg::coord_t MY_X = '0,
    parameter flit_pkg::coord_t MY_Y = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  flit_pkg::flit_t      in_flit,
    input  logic                 grant_valid,
    input  flit_pkg::vc_id_t     grant_vc,
    output route_pkg::vc_vec_t   head_valid,
    output route_pkg::port_vec_t head_port [`NUM_VC],
    output flit_pkg::stamp_t     head_time [`NUM_VC],
    output flit_pkg::flit_t      sel_flit,
    output route_pkg::vc_vec_t   credit_out
);

    import flit_pkg::*;
    import route_pkg::*;

    localparam int PTR_W = $clog2(`VC_DEPTH);

    // Extra MSB on the pointers tells full from empty
    flit_t          buf_mem [`NUM_VC][`VC_DEPTH];
    logic [PTR_W:0] wr_ptr  [`NUM_VC];
    logic [PTR_W:0] rd_ptr  [`NUM_VC];
    flit_t          head_flit [`NUM_VC];
    vc_id_t         in_vc;
    vc_vec_t        push;
    vc_vec_t        pop;

    assign in_vc = in_flit[`VC_POS];

    ////////////////////
    // Per-VC buffers
    ////////////////////

    for (genvar v = 0; v < `NUM_VC; v++) begin : g_vc

        assign push[v] = in_valid && (in_vc == vc_id_t'(v));
        assign pop[v]  = grant_valid && (grant_vc == vc_id_t'(v));

        always_ff @(posedge clk) begin
            if (rst) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
            end else begin
                if (push[v]) begin
                    wr_ptr[v] <= wr_ptr[v] + 1'b1;
                end
                if (pop[v]) begin
                    rd_ptr[v] <= rd_ptr[v] + 1'b1;
                end
            end
        end

        // Storage only, upstream credits keep it from overflowing
        always_ff @(posedge clk) begin
            if (push[v]) begin
                buf_mem[v][wr_ptr[v][PTR_W-1:0]] <= in_flit;
            end
        end

        assign head_flit[v]  = buf_mem[v][rd_ptr[v][PTR_W-1:0]];
        assign head_valid[v] = (wr_ptr[v] != rd_ptr[v]);
        assign head_time[v]  = head_flit[v][`TIME_POS];

        // Route of the head flit
        route_compute #(
            .MY_X (MY_X),
            .MY_Y (MY_Y)
        ) u_route (
            .flit_dst_x (head_flit[v][`DST_X_POS]),
            .flit_dst_y (head_flit[v][`DST_Y_POS]),
            .out_port   (head_port[v])
        );

    end

    ////////////////////
    // Pop and credits
    ////////////////////

    // Granted head goes to the crossbar this cycle
    assign sel_flit = head_flit[grant_vc];

    // One credit per flit that leaves, seen while the flit is on the output
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_out <= '0;
        end else begin
            credit_out <= pop;
        end
    end

endmodule

//--- src/route_compute.sv
`timescale 1ns/1ns
`include "router_config.svh"

module route_compute #(
    parameter flit_pkg::coord_t MY_X = '0,
    parameter flit_pkg::coord_t MY_Y = '0
) (
    input  flit_pkg::coord_t     flit_dst_x,
    input  flit_pkg::coord_t     flit_dst_y,
    output route_pkg::port_vec_t out_port
);

    // Direction numbering of the neighbour ports
    localparam int EAST  = 0;
    localparam int NORTH = 1;
    localparam int WEST  = 2;
    localparam int SOUTH = 3;

    ////////////////////
    // X first, then Y
    ////////////////////

    always_comb begin
        out_port = '0;
        if (flit_dst_x > MY_X) begin
            out_port[EAST] = 1'b1;
        end else if (flit_dst_x < MY_X) begin
            out_port[WEST] = 1'b1;
        end else if (flit_dst_y > MY_Y) begin
            out_port[NORTH] = 1'b1;
        end else if (flit_dst_y < MY_Y) begin
            out_port[SOUTH] = 1'b1;
        end else begin
            // Arrived, eject locally
            out_port[`LOCAL_PORT] = 1'b1;
        end
    end

endmodule

//--- src/route_pkg.sv
`include "router_config.svh"

package route_pkg;

    ////////////////////
    // Port addressing
    ////////////////////

    // Index of a router port, 0 to NUM_PORT-1
    typedef logic [$clog2(`NUM_PORT)-1:0] port_id_t;

    // One bit per port, one-hot for a route or a request set
    typedef logic [`NUM_PORT-1:0] port_vec_t;

    ////////////////////
    // Flow control
    ////////////////////

    // One bit per virtual channel
    typedef logic [`NUM_VC-1:0] vc_vec_t;

    // Must reach VC_DEPTH
    typedef logic [$clog2(`VC_DEPTH+1)-1:0] credit_t;

endpackage

//--- src/router.sv
`timescale 1ns/1ns
`include "router_config.svh"

module router #(
    parameter flit_pkg::coord_t MY_X = '0,
    parameter flit_pkg::coord_t MY_Y = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  route_pkg::port_vec_t in_valid,
    input  flit_pkg::flit_t      in_flit    [`NUM_PORT],
    output route_pkg::vc_vec_t   credit_out [`NUM_PORT],
    output route_pkg::port_vec_t out_valid,
    output flit_pkg::flit_t      out_flit   [`NUM_PORT],
    input  route_pkg::vc_vec_t   credit_in  [`LOCAL_PORT]
);

    import flit_pkg::*;
    import route_pkg::*;

    vc_vec_t   head_valid [`NUM_PORT];
    port_vec_t head_port  [`NUM_PORT][`NUM_VC];
    stamp_t    head_time  [`NUM_PORT][`NUM_VC];
    port_vec_t grant_valid;
    vc_id_t    grant_vc   [`NUM_PORT];
    flit_t     sel_flit   [`NUM_PORT];
    port_vec_t xbar_valid;
    port_id_t  xbar_src   [`NUM_PORT];

    ////////////////////
    // Input ports
    ////////////////////

    for (genvar i = 0; i < `NUM_PORT; i++) begin : g_in
        input_port #(
            .MY_X (MY_X),
            .MY_Y (MY_Y)
        ) u_input_port (
            .clk         (clk),
            .rst         (rst),
            .in_valid    (in_valid[i]),
            .in_flit     (in_flit[i]),
            .grant_valid (grant_valid[i]),
            .grant_vc    (grant_vc[i]),
            .head_valid  (head_valid[i]),
            .head_port   (head_port[i]),
            .head_time   (head_time[i]),
            .sel_flit    (sel_flit[i]),
            .credit_out  (credit_out[i])
        );
    end

    ////////////////////
    // Allocation
    ////////////////////

    switch_alloc u_switch_alloc (
        .clk         (clk),
        .rst         (rst),
        .head_valid  (head_valid),
        .head_port   (head_port),
        .head_time   (head_time),
        .credit_in   (credit_in),
        .grant_valid (grant_valid),
        .grant_vc    (grant_vc),
        .xbar_valid  (xbar_valid),
        .xbar_src    (xbar_src)
    );

    crossbar u_crossbar (
        .clk        (clk),
        .rst        (rst),
        .sel_flit   (sel_flit),
        .xbar_valid (xbar_valid),
        .xbar_src   (xbar_src),
        .out_valid  (out_valid),
        .out_flit   (out_flit)
    );

endmodule

//--- src/router_config.svh
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

////////////////////
// Router geometry
////////////////////

// Local port is always the last one
`define NUM_PORT      5
`define LOCAL_PORT    4
`define NUM_VC        2
`define VC_DEPTH      4

////////////////////
// Flit fields
////////////////////

`define COORD_WIDTH   2
`define TIME_WIDTH    8
`define PAYLOAD_WIDTH 16
`define FLIT_WIDTH    (2 * `COORD_WIDTH + 1 + `TIME_WIDTH + `PAYLOAD_WIDTH)

// Bit ranges inside a flit, MSB first
`define DST_X_POS     28:27
`define DST_Y_POS     26:25
`define VC_POS        24
`define TIME_POS      23:16
`define PAYLOAD_POS   15:0

`endif

//--- src/switch_alloc.sv
`timescale 1ns/1ns
`include "router_config.svh"

module switch_alloc (
    input  logic                 clk,
    input  logic                 rst,
    input  route_pkg::vc_vec_t   head_valid [`NUM_PORT],
    input  route_pkg::port_vec_t head_port  [`NUM_PORT][`NUM_VC],
    input  flit_pkg::stamp_t     head_time  [`NUM_PORT][`NUM_VC],
    input  route_pkg::vc_vec_t   credit_in  [`LOCAL_PORT],
    output route_pkg::port_vec_t grant_valid,
    output flit_pkg::vc_id_t     grant_vc   [`NUM_PORT],
    output route_pkg::port_vec_t xbar_valid,
    output route_pkg::port_id_t  xbar_src   [`NUM_PORT]
);

    import flit_pkg::*;
    import route_pkg::*;

    // Credits for the downstream buffers, neighbour outputs only
    credit_t   credit [`LOCAL_PORT][`NUM_VC];
    port_vec_t avail  [`NUM_VC];

    // Stage one winners per input
    port_vec_t st1_valid;
    vc_id_t    st1_vc   [`NUM_PORT];
    port_vec_t st1_port [`NUM_PORT];
    stamp_t    st1_time [`NUM_PORT];

    // Stage two winners per output
    stamp_t    win_time [`NUM_PORT];
    vc_id_t    win_vc   [`NUM_PORT];

    // Outputs a head may target on each VC
    always_comb begin
        for (int v = 0; v < `NUM_VC; v++) begin
            for (int o = 0; o < `LOCAL_PORT; o++) begin
                avail[v][o] = (credit[o][v] != '0);
            end
            avail[v][`LOCAL_PORT] = 1'b1;
        end
    end

    ////////////////////
    // Stage one
    ////////////////////

    // Oldest eligible head per input, lower VC on a tie
    always_comb begin
        for (int i = 0; i < `NUM_PORT; i++) begin
            st1_valid[i] = 1'b0;
            st1_vc[i]    = '0;
            st1_port[i]  = '0;
            st1_time[i]  = '0;
            for (int v = 0; v < `NUM_VC; v++) begin
                if (head_valid[i][v] && |(head_port[i][v] & avail[v]) &&
                    (!st1_valid[i] || head_time[i][v] < st1_time[i])) begin
                    st1_valid[i] = 1'b1;
                    st1_vc[i]    = vc_id_t'(v);
                    st1_port[i]  = head_port[i][v];
                    st1_time[i]  = head_time[i][v];
                end
            end
        end
    end

    ////////////////////
    // Stage two
    ////////////////////

    // Oldest requesting input per output, lower input on a tie
    always_comb begin
        for (int o = 0; o < `NUM_PORT; o++) begin
            xbar_valid[o] = 1'b0;
            xbar_src[o]   = '0;
            win_time[o]   = '0;
            win_vc[o]     = '0;
            for (int i = 0; i < `NUM_PORT; i++) begin
                if (st1_valid[i] && st1_port[i][o] &&
                    (!xbar_valid[o] || st1_time[i] < win_time[o])) begin
                    xbar_valid[o] = 1'b1;
                    xbar_src[o]   = port_id_t'(i);
                    win_time[o]   = st1_time[i];
                    win_vc[o]     = st1_vc[i];
                end
            end
        end
    end

    // Each input requests one output, so at most one grant per input
    always_comb begin
        grant_valid = '0;
        for (int o = 0; o < `NUM_PORT; o++) begin
            if (xbar_valid[o]) begin
                grant_valid[xbar_src[o]] = 1'b1;
            end
        end
        for (int i = 0; i < `NUM_PORT; i++) begin
            grant_vc[i] = st1_vc[i];
        end
    end

    ////////////////////
    // Credit counters
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int o = 0; o < `LOCAL_PORT; o++) begin
                for (int v = 0; v < `NUM_VC; v++) begin
                    credit[o][v] <= credit_t'(`VC_DEPTH);
                end
            end
        end else begin
            for (int o = 0; o < `LOCAL_PORT; o++) begin
                for (int v = 0; v < `NUM_VC; v++) begin
                    // Return and use in one cycle cancel
                    case ({credit_in[o][v], xbar_valid[o] && win_vc[o] == vc_id_t'(v)})
                        2'b10:   credit[o][v] <= credit[o][v] + 1'b1;
                        2'b01:   credit[o][v] <= credit[o][v] - 1'b1;
                        default: credit[o][v] <= credit[o][v];
                    endcase
                end
            end
        end
    end

endmodule

//--- verilog.f
+incdir+src
src/flit_pkg.sv
src/route_pkg.sv
src/route_compute.sv
src/input_port.sv
src/switch_alloc.sv
src/crossbar.sv
src/router.sv
sim/router_tb.sv
